// ==== common/cache_pkg.sv ====
// L1 cache shared definitions
// widths, address views, line type, controller states

package cache_pkg;

    // processor word and line geometry
    localparam int word_bits      = 32;
    localparam int words_per_line = 4;

    // address field widths
    localparam int offset_bits    = 2;
    localparam int index_bits     = 2;
    localparam int tag_bits       = 26;

    // memory side sees line addresses only
    localparam int line_addr_bits = tag_bits + index_bits;

    // one processor data word
    typedef logic [word_bits-1:0] word_t;

    // full cache line, word 0 in the low bits
    typedef logic [words_per_line-1:0][word_bits-1:0] line_t;

    // stored tag
    typedef logic [tag_bits-1:0] tag_t;

    // line index into the direct-mapped arrays
    typedef logic [index_bits-1:0] index_t;

    // memory line address
    typedef logic [line_addr_bits-1:0] line_addr_t;

    // processor word address, 30 bits
    // split view drives the tag lookup
    // line view drives the refill address
    typedef union packed {
        struct packed {
            tag_t                   tag;
            index_t                 index;
            logic [offset_bits-1:0] offset;
        } split;
        struct packed {
            line_addr_t             addr;
            logic [offset_bits-1:0] offset;
        } line;
    } proc_addr_u;

    // miss handling states
    // idle only right after reset
    // compare is the normal resting state
    typedef enum logic [1:0] {
        idle      = 2'b00,
        compare   = 2'b01,
        refill    = 2'b11,
        writeback = 2'b10
    } ctrl_state_t;

endpackage

// ==== l1_cache/cache_ctrl.sv ====
// L1 cache miss handling FSM
`timescale 1ns/1ns

module cache_ctrl (
    input  logic clk,
    input  logic proc_reset,
    // processor request
    input  logic proc_read,
    input  logic proc_write,
    // lookup results from the tag store
    input  logic hit,
    input  logic victim_dirty,
    // memory handshake
    input  logic mem_ready,
    output logic proc_stall,
    output logic mem_read,
    output logic mem_write,
    // store update strobes
    output logic fill,
    output logic word_we,
    output logic set_dirty,
    output logic clear_dirty
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_nxt;

    // exactly one of read and write makes a valid request
    logic req_valid;
    logic write_req;
    logic miss;

    assign req_valid = proc_read ^ proc_write;
    assign write_req = proc_write & ~proc_read;
    assign miss      = req_valid & ~hit;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::idle: begin
                state_nxt = cache_pkg::compare;
            end
            cache_pkg::compare: begin
                // dirty victim must go out before the refill
                if (miss && victim_dirty) begin
                    state_nxt = cache_pkg::writeback;
                end else if (miss) begin
                    state_nxt = cache_pkg::refill;
                end
            end
            cache_pkg::refill: begin
                // back to compare, the request hits there
                if (mem_ready) begin
                    state_nxt = cache_pkg::compare;
                end
            end
            cache_pkg::writeback: begin
                if (mem_ready) begin
                    state_nxt = cache_pkg::refill;
                end
            end
            default: begin
                state_nxt = cache_pkg::idle;
            end
        endcase
    end

    // outputs decoded from state and inputs
    always_comb begin
        proc_stall  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        fill        = 1'b0;
        word_we     = 1'b0;
        set_dirty   = 1'b0;
        clear_dirty = 1'b0;
        case (state)
            cache_pkg::idle: begin
                proc_stall = 1'b1;
            end
            cache_pkg::compare: begin
                // hits finish here with no wait cycle
                proc_stall = miss;
                if (write_req && hit) begin
                    word_we   = 1'b1;
                    set_dirty = 1'b1;
                end
            end
            cache_pkg::refill: begin
                proc_stall = 1'b1;
                mem_read   = 1'b1;
                // line, tag and valid only taken on the ready edge
                fill       = mem_ready;
            end
            cache_pkg::writeback: begin
                proc_stall  = 1'b1;
                mem_write   = 1'b1;
                clear_dirty = mem_ready;
            end
            default: begin
                proc_stall = 1'b1;
            end
        endcase
    end

    // state register
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= cache_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== l1_cache/line_store.sv ====
// L1 cache line data store
`timescale 1ns/1ns

module line_store (
    input  logic                                clk,
    input  logic                                proc_reset,
    // line and word select
    input  cache_pkg::index_t                   index,
    input  logic [cache_pkg::offset_bits-1:0]   offset,
    // single word write from the processor
    input  cache_pkg::word_t                    wdata,
    input  logic                                word_we,
    // full line write from memory
    input  logic                                fill,
    input  cache_pkg::line_t                    fill_line,
    // read paths
    output cache_pkg::word_t                    rd_word,
    output cache_pkg::line_t                    victim_line
);

    localparam int num_lines = 1 << cache_pkg::index_bits;

    cache_pkg::line_t lines [num_lines];

    // word read for the processor, no latency
    assign rd_word     = lines[index][offset];

    // whole line for writeback
    assign victim_line = lines[index];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int i = 0; i < num_lines; i++) begin
                lines[i] <= '0;
            end
        end else begin
            // refill replaces the whole line
            if (fill) begin
                lines[index] <= fill_line;
            end else if (word_we) begin
                // write hit touches one word only
                lines[index][offset] <= wdata;
            end
        end
    end

endmodule

// ==== l1_cache/tag_store.sv ====
// L1 cache tag, valid and dirty store
`timescale 1ns/1ns

module tag_store (
    input  logic              clk,
    input  logic              proc_reset,
    // lookup address fields
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    // update strobes
    input  logic              fill,
    input  logic              set_dirty,
    input  logic              clear_dirty,
    // lookup results
    output logic              hit,
    output logic              victim_dirty,
    output cache_pkg::tag_t   victim_tag
);

    localparam int num_lines = 1 << cache_pkg::index_bits;

    // per line state
    logic            valid [num_lines];
    logic            dirty [num_lines];
    cache_pkg::tag_t tags  [num_lines];

    // combinational lookup at the indexed line
    assign hit          = valid[index] && (tags[index] == tag);
    assign victim_dirty = dirty[index];

    // tag of whatever line sits at the index now
    assign victim_tag   = tags[index];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int i = 0; i < num_lines; i++) begin
                valid[i] <= 1'b0;
                dirty[i] <= 1'b0;
                tags[i]  <= '0;
            end
        end else begin
            // refill installs a clean line
            if (fill) begin
                tags[index]  <= tag;
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;
            end else if (set_dirty) begin
                // write hit
                dirty[index] <= 1'b1;
            end else if (clear_dirty) begin
                // victim now written back
                dirty[index] <= 1'b0;
            end
        end
    end

endmodule

// ==== project.f ====
common/cache_pkg.sv
l1_cache/tag_store.sv
l1_cache/line_store.sv
l1_cache/cache_ctrl.sv
verilog/cache_top.sv
verif/cache_tb.sv

// ==== verif/cache_tb.sv ====
// L1 cache testbench
`timescale 1ns/1ns

module cache_tb;

    // directed requests plus the random mix
    localparam int random_requests = 400;
    localparam int total_requests  = 13 + random_requests;
    localparam int timeout_cycles  = 16 + 12 * total_requests + 40;
    localparam logic [31:0] pattern_key = 32'h3c5a_96e1;

    logic                  clk = 1'b0;
    logic                  proc_reset;
    logic                  proc_read;
    logic                  proc_write;
    cache_pkg::proc_addr_u proc_addr;
    cache_pkg::word_t      proc_wdata;
    logic                  proc_stall;
    cache_pkg::word_t      proc_rdata;
    logic                  mem_ready = 1'b0;
    cache_pkg::line_t      mem_rdata = '0;
    logic                  mem_read;
    logic                  mem_write;
    cache_pkg::line_addr_t mem_addr;
    cache_pkg::line_t      mem_wdata;

    integer seed = 32'hf246_61be;
    int     error_count = 0;
    int     reads_checked = 0;
    int     wb_count = 0;
    int     refill_count = 0;
    cache_pkg::line_addr_t last_wb_addr = '0;

    // memory contents seen by the processor, and what memory really holds
    cache_pkg::word_t ref_img [logic [29:0]];
    cache_pkg::line_t mem_img [cache_pkg::line_addr_t];

    cache_top cache_top_inst (.*);

    always #10 clk = ~clk;

    // untouched memory word built from the full word address
    function automatic cache_pkg::word_t pattern_word(input logic [29:0] waddr);
        pattern_word = {2'b00, waddr} ^ pattern_key;
    endfunction

    // reference model returns the latest processor write or the initial pattern
    function automatic cache_pkg::word_t expected_word(input logic [29:0] waddr);
        if (ref_img.exists(waddr)) begin
            expected_word = ref_img[waddr];
        end else begin
            expected_word = pattern_word(waddr);
        end
    endfunction

    function automatic cache_pkg::line_t ref_line(input cache_pkg::line_addr_t la);
        for (int k = 0; k < cache_pkg::words_per_line; k++) begin
            ref_line[k] = expected_word({la, k[1:0]});
        end
    endfunction

    // what the next level returns on a refill
    function automatic cache_pkg::line_t mem_line(input cache_pkg::line_addr_t la);
        if (mem_img.exists(la)) begin
            mem_line = mem_img[la];
        end else begin
            for (int k = 0; k < cache_pkg::words_per_line; k++) begin
                mem_line[k] = pattern_word({la, k[1:0]});
            end
        end
    endfunction

    function automatic logic [29:0] make_addr(input cache_pkg::tag_t t,
                                              input cache_pkg::index_t i,
                                              input logic [1:0] o);
        make_addr = {t, i, o};
    endfunction

    task automatic report_fail(input string msg);
        error_count++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_line(input cache_pkg::line_t got, input cache_pkg::line_t exp,
                              input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_addr(input cache_pkg::line_addr_t got,
                              input cache_pkg::line_addr_t exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    // hold one request until stall drops at an edge
    task automatic issue(input logic rd, input logic wr, input logic [29:0] a,
                         input cache_pkg::word_t d, output int waited);
        waited = 0;
        proc_read  <= rd;
        proc_write <= wr;
        proc_addr  <= a;
        proc_wdata <= d;
        @(posedge clk);
        while (proc_stall) begin
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic go_idle();
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(posedge clk);
    endtask

    // memory model with 0 to 3 wait cycles per access
    always @(posedge clk) begin : memory_model
        int   wait_left;
        logic busy;
        if (proc_reset) begin
            mem_ready <= 1'b0;
            wait_left = 0;
            busy = 1'b0;
        end else if (mem_ready) begin
            // access completes at this edge
            if (mem_write) begin
                check_line(mem_wdata, ref_line(mem_addr), "write-back data");
                mem_img[mem_addr] = mem_wdata;
                last_wb_addr = mem_addr;
                wb_count++;
            end else if (mem_read) begin
                refill_count++;
            end
            mem_ready <= 1'b0;
        end else if (mem_read || mem_write) begin
            if (mem_read && mem_write) begin
                report_fail("mem_read and mem_write high together");
            end
            if (!busy) begin
                wait_left = $random(seed) & 3;
                busy = 1'b1;
            end
            if (wait_left == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem_line(mem_addr);
                busy = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // completed reads against the reference, completed writes into it
    always @(posedge clk) begin
        if (!proc_reset && !proc_stall) begin
            if (proc_read && !proc_write) begin
                check_word(proc_rdata, expected_word(proc_addr), "read data");
                reads_checked++;
            end else if (proc_write && !proc_read) begin
                ref_img[proc_addr] = proc_wdata;
            end
        end
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired, a request never completed");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int               waited;
        int               wb0;
        int               rf0;
        logic [31:0]      rnd;
        cache_pkg::tag_t  rnd_tag;
        cache_pkg::word_t rnd_data;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        repeat (16) @(posedge clk);
        proc_reset <= 1'b0;
        @(posedge clk);

        // quiet while no request is up
        repeat (6) begin
            @(posedge clk);
            if (proc_stall !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
                report_fail("stall or memory strobe high with no request");
            end
        end

        // fresh reads refill from the pattern
        for (int i = 0; i < 4; i++) begin
            wb0 = wb_count;
            rf0 = refill_count;
            issue(1'b1, 1'b0, make_addr(26'h1, i[1:0], i[1:0]), '0, waited);
            check_count(refill_count - rf0, 1, "refills on fresh read");
            check_count(wb_count - wb0, 0, "write-backs on fresh read");
            if (waited == 0) begin
                report_fail("fresh read completed without a stall");
            end
        end

        // write hit then reads of the same line
        rf0 = refill_count;
        issue(1'b0, 1'b1, make_addr(26'h1, 2'd2, 2'd1), 32'hdead_0001, waited);
        issue(1'b1, 1'b0, make_addr(26'h1, 2'd2, 2'd1), '0, waited);
        issue(1'b1, 1'b0, make_addr(26'h1, 2'd2, 2'd0), '0, waited);
        issue(1'b1, 1'b0, make_addr(26'h1, 2'd2, 2'd2), '0, waited);
        issue(1'b1, 1'b0, make_addr(26'h1, 2'd2, 2'd3), '0, waited);
        check_count(refill_count - rf0, 0, "refills on hits");

        // dirty eviction writes the victim back once
        wb0 = wb_count;
        rf0 = refill_count;
        issue(1'b1, 1'b0, make_addr(26'h5, 2'd2, 2'd0), '0, waited);
        check_count(wb_count - wb0, 1, "write-backs on dirty eviction");
        check_count(refill_count - rf0, 1, "refills on dirty eviction");
        check_addr(last_wb_addr, {26'h1, 2'd2}, "write-back line address");
        issue(1'b0, 1'b1, make_addr(26'h5, 2'd2, 2'd3), 32'hbeef_0005, waited);
        wb0 = wb_count;
        // earlier write comes back from memory
        issue(1'b1, 1'b0, make_addr(26'h1, 2'd2, 2'd1), '0, waited);
        check_count(wb_count - wb0, 1, "write-backs on second dirty eviction");
        check_addr(last_wb_addr, {26'h5, 2'd2}, "write-back line address");

        // clean eviction is a refill only
        wb0 = wb_count;
        rf0 = refill_count;
        issue(1'b1, 1'b0, make_addr(26'h7, 2'd3, 2'd2), '0, waited);
        check_count(wb_count - wb0, 0, "write-backs on clean eviction");
        check_count(refill_count - rf0, 1, "refills on clean eviction");

        // random mix of reads and writes over tags 1, 5, 9 and 13
        for (int n = 0; n < random_requests; n++) begin
            if (($random(seed) & 7) == 0) begin
                go_idle();
            end
            rnd      = $random(seed);
            rnd_data = $random(seed);
            rnd_tag  = {22'h0, rnd[1:0], 2'b01};
            issue(rnd[6], ~rnd[6], make_addr(rnd_tag, rnd[3:2], rnd[5:4]), rnd_data,
                  waited);
        end
        go_idle();
        repeat (4) @(posedge clk);

        $display("reads checked: %0d, write-backs: %0d, refills: %0d, errors: %0d",
                 reads_checked, wb_count, refill_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/cache_top.sv ====
// L1 data cache top level
// direct mapped, write back, write allocate
`timescale 1ns/1ns

module cache_top (
    input  logic                  clk,
    input  logic                  proc_reset,
    // processor side
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::proc_addr_u proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output logic                  proc_stall,
    output cache_pkg::word_t      proc_rdata,
    // next level memory side
    input  logic                  mem_ready,
    input  cache_pkg::line_t      mem_rdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata
);

    // lookup results
    logic            hit;
    logic            victim_dirty;
    cache_pkg::tag_t victim_tag;

    // update strobes from the controller
    logic fill;
    logic word_we;
    logic set_dirty;
    logic clear_dirty;

    // data store outputs
    cache_pkg::word_t rd_word;
    cache_pkg::line_t victim_line;

    cache_ctrl cache_ctrl_inst (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .fill         (fill),
        .word_we      (word_we),
        .set_dirty    (set_dirty),
        .clear_dirty  (clear_dirty)
    );

    tag_store tag_store_inst (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (proc_addr.split.index),
        .tag          (proc_addr.split.tag),
        .fill         (fill),
        .set_dirty    (set_dirty),
        .clear_dirty  (clear_dirty),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    line_store line_store_inst (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (proc_addr.split.index),
        .offset       (proc_addr.split.offset),
        .wdata        (proc_wdata),
        .word_we      (word_we),
        .fill         (fill),
        .fill_line    (mem_rdata),
        .rd_word      (rd_word),
        .victim_line  (victim_line)
    );

    // writeback targets the victim line, everything else the requested line
    assign mem_addr = mem_write ? {victim_tag, proc_addr.split.index}
                                : proc_addr.line.addr;

    // only sampled by memory while mem_write is up
    assign mem_wdata  = victim_line;
    assign proc_rdata = rd_word;

endmodule
